/* logic/cdb_snoop.sv */
`timescale 1ns/1ps
`include "rs_defs.svh"

module cdb_snoop import rs_pkg::*; (
        input  rob_tag_t       tag,
        input  logic           busy,
        input  word_t          value,
        input  cdb_valid_vec_t cdb_valid,
        input  cdb_tag_vec_t   cdb_tag,
        input  cdb_word_vec_t  cdb_value,
        output logic           ready,
        output word_t          result
);

        // resolve one operand against the broadcast buses
        always_comb begin
                // operand not waiting, pass register value through
                ready  = !busy;
                result = value;
                if (busy) begin
                        // walk down so the lowest matching bus is the last to win
                        for (int i = `RS_CDB_PORTS - 1; i >= 0; i--) begin
                                if (cdb_valid[i] && (cdb_tag[i] == tag)) begin
                                        ready  = 1'b1;
                                        result = cdb_value[i];
                                end
                        end
                end
                // no hit, operand keeps waiting on its tag
        end

endmodule

/* logic/collapse_array.sv */
`timescale 1ns/1ps
`include "rs_defs.svh"

module collapse_array import rs_pkg::*; #(
        parameter type payload_t = logic
) (
        input  logic      clk,
        input  logic      rst,
        input  logic      flush,
        input  logic      write,
        input  slot_idx_t write_slot,
        input  payload_t  write_data,
        input  logic      shift,
        input  slot_idx_t shift_from,
        input  slot_idx_t read_slot,
        output payload_t  read_data
);

        payload_t mem [`RS_DEPTH];

        always_ff @(posedge clk) begin
                if (rst || flush) begin
                        for (int i = 0; i < `RS_DEPTH; i++) begin
                                mem[i] <= '0;
                        end
                end else begin
                        if (shift) begin
                                // close the gap left by the issued slot
                                for (int i = 0; i < `RS_DEPTH - 1; i++) begin
                                        if (i >= int'(shift_from)) begin
                                                mem[i] <= mem[i + 1];
                                        end
                                end
                                // top slot always vacated by a collapse
                                mem[`RS_DEPTH - 1] <= '0;
                        end
                        // write slot is already the post-collapse tail
                        if (write) begin
                                mem[write_slot] <= write_data;
                        end
                end
        end

        // issue path reads straight from the store
        assign read_data = mem[read_slot];

endmodule

/* logic/ready_select.sv */
`timescale 1ns/1ps
`include "rs_defs.svh"

module ready_select import rs_pkg::*; (
        input  logic [`RS_DEPTH-1:0] slot_ready,
        input  logic                 fu_busy,
        output logic                 found,
        output slot_idx_t            pick
);

        logic any_ready;

        // lowest index is the oldest, so it wins
        always_comb begin
                any_ready = 1'b0;
                pick      = '0;
                for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
                        if (slot_ready[i]) begin
                                any_ready = 1'b1;
                                pick      = slot_idx_t'(i);
                        end
                end
        end

        // function unit busy holds every issue
        assign found = any_ready && !fu_busy;

endmodule

/* logic/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station import rs_pkg::*; (
        input  logic           clk,
        input  logic           rst,
        input  logic           flush,
        // dispatch side
        input  logic           dispatch,
        input  rs_insn_t       insn,
        input  rs_trace_t      trace,
        input  rob_tag_t       src1_tag,
        input  rob_tag_t       src2_tag,
        input  logic           src1_busy,
        input  logic           src2_busy,
        input  word_t          src1_value,
        input  word_t          src2_value,
        // result buses
        input  cdb_valid_vec_t cdb_valid,
        input  cdb_tag_vec_t   cdb_tag,
        input  cdb_word_vec_t  cdb_value,
        // issue side
        input  logic           fu_busy,
        output logic           issue_valid,
        output rs_insn_t       issue_insn,
        output word_t          issue_src1,
        output word_t          issue_src2,
        output rs_trace_t      issue_trace,
        output logic           full,
        output logic           empty
);

        logic  cap1_ready;
        logic  cap2_ready;
        word_t cap1_value;
        word_t cap2_value;

        // same-cycle broadcast capture for source 1
        cdb_snoop u_src1_capture (
                .tag       (src1_tag),
                .busy      (src1_busy),
                .value     (src1_value),
                .cdb_valid (cdb_valid),
                .cdb_tag   (cdb_tag),
                .cdb_value (cdb_value),
                .ready     (cap1_ready),
                .result    (cap1_value)
        );

        // and for source 2
        cdb_snoop u_src2_capture (
                .tag       (src2_tag),
                .busy      (src2_busy),
                .value     (src2_value),
                .cdb_valid (cdb_valid),
                .cdb_tag   (cdb_tag),
                .cdb_value (cdb_value),
                .ready     (cap2_ready),
                .result    (cap2_value)
        );

        // queue, wakeup and oldest-ready issue
        rs_slots u_slots (
                .clk          (clk),
                .rst          (rst),
                .flush        (flush),
                .write        (dispatch),
                .write_insn   (insn),
                .write_trace  (trace),
                .write_tag1   (src1_tag),
                .write_tag2   (src2_tag),
                .write_ready1 (cap1_ready),
                .write_ready2 (cap2_ready),
                .write_value1 (cap1_value),
                .write_value2 (cap2_value),
                .cdb_valid    (cdb_valid),
                .cdb_tag      (cdb_tag),
                .cdb_value    (cdb_value),
                .fu_busy      (fu_busy),
                .issue_valid  (issue_valid),
                .issue_insn   (issue_insn),
                .issue_src1   (issue_src1),
                .issue_src2   (issue_src2),
                .issue_trace  (issue_trace),
                .full         (full),
                .empty        (empty)
        );

endmodule

/* logic/rs_defs.svh */
`ifndef RS_DEFS_SVH
`define RS_DEFS_SVH

// slots in the station, oldest entry sits in slot 0
`define RS_DEPTH 4

// result buses snooped each cycle
`define RS_CDB_PORTS 4

// reorder buffer tag width
`define RS_TAG_W 4

// datapath width, rv32i
`define RS_XLEN 32

`endif

/* logic/rs_pkg.sv */
`include "rs_defs.svh"

package rs_pkg;

        // one register value
        typedef logic [`RS_XLEN-1:0] word_t;

        // reorder buffer tag
        typedef logic [`RS_TAG_W-1:0] rob_tag_t;

        // slot number, 0 is the oldest entry
        typedef logic [1:0] slot_idx_t;

        // fields fixed for the life of an entry
        typedef struct packed {
                logic [6:0] opcode;
                logic [2:0] alu_op;
                logic [2:0] cmp_op;
                logic [1:0] mul_op;
                logic [4:0] rd;
                // tag of this instruction in the rob
                rob_tag_t   rob_tag;
                word_t      pc;
                word_t      imm;
        } rs_insn_t;

        // retirement trace record, carried untouched
        typedef struct packed {
                word_t order;
                word_t insn_word;
        } rs_trace_t;

        // result bus bundle, bus 0 has priority
        typedef word_t    [`RS_CDB_PORTS-1:0] cdb_word_vec_t;
        typedef rob_tag_t [`RS_CDB_PORTS-1:0] cdb_tag_vec_t;
        typedef logic     [`RS_CDB_PORTS-1:0] cdb_valid_vec_t;

endpackage

/* logic/rs_slots.sv */
`timescale 1ns/1ps
`include "rs_defs.svh"

module rs_slots import rs_pkg::*; (
        input  logic           clk,
        input  logic           rst,
        input  logic           flush,
        input  logic           write,
        input  rs_insn_t       write_insn,
        input  rs_trace_t      write_trace,
        input  rob_tag_t       write_tag1,
        input  rob_tag_t       write_tag2,
        input  logic           write_ready1,
        input  logic           write_ready2,
        input  word_t          write_value1,
        input  word_t          write_value2,
        input  cdb_valid_vec_t cdb_valid,
        input  cdb_tag_vec_t   cdb_tag,
        input  cdb_word_vec_t  cdb_value,
        input  logic           fu_busy,
        output logic           issue_valid,
        output rs_insn_t       issue_insn,
        output word_t          issue_src1,
        output word_t          issue_src2,
        output rs_trace_t      issue_trace,
        output logic           full,
        output logic           empty
);

        localparam int CNT_W = $clog2(`RS_DEPTH + 1);

        // occupancy, slots below count hold live entries
        logic [CNT_W-1:0] count;
        logic [CNT_W-1:0] tail_cnt;
        slot_idx_t        tail;

        // operand state, first index is the source operand
        rob_tag_t op_tag  [2][`RS_DEPTH];
        logic     op_rdy  [2][`RS_DEPTH];
        word_t    op_val  [2][`RS_DEPTH];
        logic     snp_rdy [2][`RS_DEPTH];
        word_t    snp_val [2][`RS_DEPTH];
        rob_tag_t nxt_tag [2][`RS_DEPTH];
        logic     nxt_rdy [2][`RS_DEPTH];
        word_t    nxt_val [2][`RS_DEPTH];

        // dispatch operands lined up by source
        rob_tag_t wr_tag [2];
        logic     wr_rdy [2];
        word_t    wr_val [2];

        logic [`RS_DEPTH-1:0] slot_ready;
        logic                 found;
        slot_idx_t            pick;
        logic                 do_issue;
        logic                 do_write;

        assign wr_tag[0] = write_tag1;
        assign wr_tag[1] = write_tag2;
        assign wr_rdy[0] = write_ready1;
        assign wr_rdy[1] = write_ready2;
        assign wr_val[0] = write_value1;
        assign wr_val[1] = write_value2;

        assign full  = (count == CNT_W'(`RS_DEPTH));
        assign empty = (count == '0);

        // flush blocks both ends of the queue
        assign do_issue = found && !flush;
        assign do_write = write && !full && !flush;

        // new entry lands after the collapse
        assign tail_cnt = count - CNT_W'(do_issue);
        assign tail     = slot_idx_t'(tail_cnt);

        // wakeup snoop on every waiting operand
        for (genvar op = 0; op < 2; op++) begin : g_op
                for (genvar s = 0; s < `RS_DEPTH; s++) begin : g_slot
                        cdb_snoop u_wake (
                                .tag       (op_tag[op][s]),
                                .busy      (!op_rdy[op][s]),
                                .value     (op_val[op][s]),
                                .cdb_valid (cdb_valid),
                                .cdb_tag   (cdb_tag),
                                .cdb_value (cdb_value),
                                .ready     (snp_rdy[op][s]),
                                .result    (snp_val[op][s])
                        );
                end
        end

        // live and both operands in hand
        always_comb begin
                for (int i = 0; i < `RS_DEPTH; i++) begin
                        slot_ready[i] = (i < int'(count)) && op_rdy[0][i] && op_rdy[1][i];
                end
        end

        ready_select u_select (
                .slot_ready (slot_ready),
                .fu_busy    (fu_busy),
                .found      (found),
                .pick       (pick)
        );

        // next operand state
        always_comb begin
                for (int op = 0; op < 2; op++) begin
                        // hold in place, picking up this cycle's wakeups
                        for (int i = 0; i < `RS_DEPTH; i++) begin
                                nxt_tag[op][i] = op_tag[op][i];
                                nxt_rdy[op][i] = snp_rdy[op][i];
                                nxt_val[op][i] = snp_val[op][i];
                        end
                        // collapse, a wakeup follows its entry down
                        for (int i = 0; i < `RS_DEPTH - 1; i++) begin
                                if (do_issue && i >= int'(pick)) begin
                                        nxt_tag[op][i] = op_tag[op][i + 1];
                                        nxt_rdy[op][i] = snp_rdy[op][i + 1];
                                        nxt_val[op][i] = snp_val[op][i + 1];
                                end
                        end
                        if (do_issue) begin
                                nxt_rdy[op][`RS_DEPTH - 1] = 1'b0;
                        end
                        // dispatch wins the tail slot
                        if (do_write) begin
                                nxt_tag[op][tail] = wr_tag[op];
                                nxt_rdy[op][tail] = wr_rdy[op];
                                nxt_val[op][tail] = wr_val[op];
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (rst || flush) begin
                        count  <= '0;
                        op_rdy <= '{default: 1'b0};
                end else begin
                        count  <= count + CNT_W'(do_write) - CNT_W'(do_issue);
                        op_rdy <= nxt_rdy;
                end
        end

        // tags and values only matter once ready bits say so
        always_ff @(posedge clk) begin
                op_tag <= nxt_tag;
                op_val <= nxt_val;
        end

        collapse_array #(.payload_t(rs_insn_t)) u_insn_array (
                .clk        (clk),
                .rst        (rst),
                .flush      (flush),
                .write      (do_write),
                .write_slot (tail),
                .write_data (write_insn),
                .shift      (do_issue),
                .shift_from (pick),
                .read_slot  (pick),
                .read_data  (issue_insn)
        );

        collapse_array #(.payload_t(rs_trace_t)) u_trace_array (
                .clk        (clk),
                .rst        (rst),
                .flush      (flush),
                .write      (do_write),
                .write_slot (tail),
                .write_data (write_trace),
                .shift      (do_issue),
                .shift_from (pick),
                .read_slot  (pick),
                .read_data  (issue_trace)
        );

        assign issue_valid = do_issue;
        assign issue_src1  = op_val[0][pick];
        assign issue_src2  = op_val[1][pick];

endmodule

/* sources.f */
+incdir+logic
logic/rs_pkg.sv
logic/cdb_snoop.sv
logic/ready_select.sv
logic/collapse_array.sv
logic/rs_slots.sv
logic/reservation_station.sv
testbench/reservation_station_sva.sv
testbench/tb_reservation_station.sv

/* testbench/reservation_station_sva.sv */
`timescale 1ns/1ps

module reservation_station_sva (
        input logic clk,
        input logic rst,
        input logic flush,
        input logic fu_busy,
        input logic issue_valid,
        input logic full,
        input logic empty
);

        // failing assertions so far
        int error_count = 0;

        // occupancy count drives both flags, never both at once
        a_full_empty : assert property (@(posedge clk) disable iff (rst)
                !(full && empty))
                else begin
                        error_count++;
                        $error("full and empty high in the same cycle");
                end

        // flush and a busy unit both hold the issue port
        a_issue_held : assert property (@(posedge clk) disable iff (rst)
                (flush || fu_busy) |-> !issue_valid)
                else begin
                        error_count++;
                        $error("issue under flush or fu_busy");
                end

        // nothing to pick from an empty station
        a_empty_idle : assert property (@(posedge clk) disable iff (rst)
                empty |-> !issue_valid)
                else begin
                        error_count++;
                        $error("issue while empty");
                end

endmodule

bind reservation_station reservation_station_sva u_sva (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .fu_busy     (fu_busy),
        .issue_valid (issue_valid),
        .full        (full),
        .empty       (empty)
);

/* testbench/rs_cases.txt */
// w0 ctrl digits: dispatch src1_busy src2_busy fu_busy flush | exp valid full empty
// w1 tags: insn src1 src2 exp_issue | cdb3..cdb0, w2: cdb_valid3..0 disp_order exp_order
// w3 src1_value, w4 src2_value, w5 exp_src1, w6 exp_src2; ffffffff ends the rows
00000001 00000000 00000000 00000000 00000000 00000000 00000000
10000001 10000000 00000100 11111111 22222222 00000000 00000000
00000100 00010000 00000001 00000000 00000000 11111111 22222222
00000001 00000000 00000000 00000000 00000000 00000000 00000000
11000001 25000550 01100200 deadbeef 33333333 00000000 00000000
00000100 00020000 00000002 00000000 00000000 c0de0105 33333333
10100001 30700000 00000300 44444444 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00007007 10010000 00000000 00000000 00000000 00000000
00000100 00030000 00000003 00000000 00000000 44444444 c0de0007
10010001 40000000 00000400 40000001 40000002 00000000 00000000
11010000 59000000 00000500 00000000 50000002 00000000 00000000
10010000 60000000 00000600 60000001 60000002 00000000 00000000
10010000 80000000 00000700 80000001 80000002 00000000 00000000
10010010 a0000000 00000800 a0000001 a0000002 00000000 00000000
00000110 00040900 01000004 00000000 00000000 40000001 40000002
10000100 b0050000 00000905 b0000001 b0000002 c0de0209 50000002
00010000 00000000 00000000 00000000 00000000 00000000 00000000
00000100 00060000 00000006 00000000 00000000 60000001 60000002
10001000 c0000000 00000a00 c0000001 c0000002 00000000 00000000
00000001 00000000 00000000 00000000 00000000 00000000 00000000
11000001 de000000 00000b00 00000000 d0000002 00000000 00000000
10000000 f0000000 00000c00 f0000001 f0000002 00000000 00000000
10000100 100fe000 10000d0c 1a1a1a1a 1b1b1b1b f0000001 f0000002
00000100 000d0000 0000000b 00000000 00000000 c0de030e d0000002
00000100 00010000 0000000d 00000000 00000000 1a1a1a1a 1b1b1b1b
00000001 00000000 00000000 00000000 00000000 00000000 00000000
ffffffff

/* testbench/tb_reservation_station.sv */
`timescale 1ns/1ps
`include "rs_defs.svh"

module tb_reservation_station import rs_pkg::*; ();

        // seven hex words per cycle row
        localparam int          ROW_WORDS = 7;
        localparam int          MAX_ROWS  = 64;
        localparam logic [31:0] END_MARK  = 32'hffff_ffff;

        logic           clk, rst, flush, dispatch, fu_busy;
        rs_insn_t       insn;
        rs_trace_t      trace;
        rob_tag_t       src1_tag, src2_tag;
        logic           src1_busy, src2_busy;
        word_t          src1_value, src2_value;
        cdb_valid_vec_t cdb_valid;
        cdb_tag_vec_t   cdb_tag;
        cdb_word_vec_t  cdb_value;
        logic           issue_valid, full, empty;
        rs_insn_t       issue_insn;
        word_t          issue_src1, issue_src2;
        rs_trace_t      issue_trace;

        logic [31:0] case_words [MAX_ROWS*ROW_WORDS];
        int          row;
        logic        done;

        reservation_station u_reservation_station (.*);

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        // instruction fields all follow from the rob tag
        function automatic rs_insn_t make_insn(input rob_tag_t tag);
                rs_insn_t v;
                v.opcode  = 7'h33;
                v.alu_op  = tag[2:0];
                v.cmp_op  = ~tag[2:0];
                v.mul_op  = tag[1:0];
                v.rd      = {1'b1, tag};
                v.rob_tag = tag;
                v.pc      = 32'h0000_1000 + word_t'(tag) * 4;
                v.imm     = word_t'(tag);
                return v;
        endfunction

        // addi word with the order number as immediate
        function automatic rs_trace_t make_trace(input logic [7:0] ord);
                rs_trace_t v;
                v.order     = word_t'(ord);
                v.insn_word = 32'h0000_0013 | (word_t'(ord) << 20);
                return v;
        endfunction

        // every bus carries its own index, so the winning bus shows in the value
        function automatic word_t bus_value(input int bus, input rob_tag_t tag);
                return 32'hc0de_0000 | (word_t'(bus) << 8) | word_t'(tag);
        endfunction

        task automatic halt_on_error();
                $display("ERRORS FOUND");
                $fatal(1, "run stopped at first error");
        endtask

        task automatic check_flag(input logic got, input logic exp, input string what);
                if (got !== exp) begin
                        $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
                        halt_on_error();
                end
        endtask

        task automatic check_word(input word_t got, input word_t exp, input string what);
                if (got !== exp) begin
                        $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
                        halt_on_error();
                end
        endtask

        task automatic check_insn(input rs_insn_t got, input rs_insn_t exp, input string what);
                if (got !== exp) begin
                        $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
                        halt_on_error();
                end
        endtask

        task automatic check_trace(input rs_trace_t got, input rs_trace_t exp, input string what);
                if (got !== exp) begin
                        $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
                        halt_on_error();
                end
        endtask

        // bound checker tally, nonzero once any assertion has fired
        task automatic check_assertions();
                if (u_reservation_station.u_sva.error_count != 0) begin
                        $display("a bound assertion failed before %0t", $time);
                        halt_on_error();
                end
        endtask

        task automatic drive_row(input int r);
                logic [31:0] ctrl;
                logic [31:0] tags;
                logic [31:0] misc;
                ctrl       = case_words[r*ROW_WORDS];
                tags       = case_words[r*ROW_WORDS + 1];
                misc       = case_words[r*ROW_WORDS + 2];
                dispatch   = ctrl[28];
                src1_busy  = ctrl[24];
                src2_busy  = ctrl[20];
                fu_busy    = ctrl[16];
                flush      = ctrl[12];
                insn       = make_insn(tags[31:28]);
                src1_tag   = tags[27:24];
                src2_tag   = tags[23:20];
                trace      = make_trace(misc[15:8]);
                src1_value = case_words[r*ROW_WORDS + 3];
                src2_value = case_words[r*ROW_WORDS + 4];
                // bus i from tag nibble i, valid from misc digit 4+i
                for (int i = 0; i < `RS_CDB_PORTS; i++) begin
                        cdb_tag[i]   = tags[4*i +: 4];
                        cdb_valid[i] = misc[16 + 4*i];
                        cdb_value[i] = bus_value(i, tags[4*i +: 4]);
                end
        endtask

        task automatic check_row(input int r);
                logic [31:0] ctrl;
                logic [31:0] tags;
                logic [31:0] misc;
                string       where;
                ctrl  = case_words[r*ROW_WORDS];
                tags  = case_words[r*ROW_WORDS + 1];
                misc  = case_words[r*ROW_WORDS + 2];
                where = $sformatf("row %0d", r);
                check_flag(issue_valid, ctrl[8], {where, " issue_valid"});
                check_flag(full, ctrl[4], {where, " full"});
                check_flag(empty, ctrl[0], {where, " empty"});
                // payload only means something on an issue cycle
                if (ctrl[8]) begin
                        check_insn(issue_insn, make_insn(tags[19:16]), {where, " issue_insn"});
                        check_word(issue_src1, case_words[r*ROW_WORDS + 5], {where, " src1"});
                        check_word(issue_src2, case_words[r*ROW_WORDS + 6], {where, " src2"});
                        check_trace(issue_trace, make_trace(misc[7:0]), {where, " trace"});
                end
        endtask

        initial begin
                rst        = 1'b1;
                flush      = 1'b0;
                dispatch   = 1'b0;
                fu_busy    = 1'b0;
                insn       = '0;
                trace      = '0;
                src1_tag   = '0;
                src2_tag   = '0;
                src1_busy  = 1'b0;
                src2_busy  = 1'b0;
                src1_value = '0;
                src2_value = '0;
                cdb_valid  = '0;
                cdb_tag    = '0;
                cdb_value  = '0;
                $readmemh("testbench/rs_cases.txt", case_words);
                repeat (2) @(posedge clk);
                #1;
                rst  = 1'b0;
                row  = 0;
                done = 1'b0;
                // one row per cycle until the end marker
                while (!done) begin
                        if (row >= MAX_ROWS) begin
                                $display("timeout, no end marker within %0d rows", MAX_ROWS);
                                halt_on_error();
                        end
                        if (case_words[row*ROW_WORDS] === END_MARK) begin
                                done = 1'b1;
                        end else begin
                                drive_row(row);
                                // sample just ahead of the next rising edge
                                #8;
                                check_row(row);
                                @(posedge clk);
                                #1;
                                check_assertions();
                                row++;
                        end
                end
                $display("NO ERRORS");
                $finish;
        end

endmodule
